//--- Bender.yml
package:
  name: cpu_pipeline

sources:
  - include_dirs:
      - src
    files:
      - src/cpu_pkg.sv
      - src/stage_reg.sv
      - src/decode_stage.sv
      - src/hazard_forward.sv
      - src/execute_stage.sv
      - src/mem_access.sv
      - src/cpu_top.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/cpu_tb.sv

//--- dv/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb
   import cpu_pkg::*;
();

   // Five short programs of under 40 cycles each plus margin
   localparam int MAX_CYCLES = 400;
   localparam int IMEM_WORDS = 64;
   localparam int DMEM_WORDS = 256;

   logic        clk;
   logic        rst_n;
   logic        rst_req;
   logic [31:0] inst;
   logic [31:0] rdata;
   logic [31:0] iaddr;
   logic [31:0] daddr;
   logic [31:0] wdata;
   logic [1:0]  gran;
   logic [3:0]  we;
   logic [3:0]  re;
   logic        halt;
   logic        err;

   logic [31:0] imem [0:IMEM_WORDS-1];
   logic [31:0] dmem [0:DMEM_WORDS-1];
   logic [31:0] mregs [0:31];

   // Access record is {gran, lanes, addr, data}
   logic [69:0] exp_st[$];
   logic [69:0] exp_ld[$];
   logic [69:0] obs_st[$];
   logic [69:0] obs_ld[$];
   logic [31:0] iaddr_log[$];

   int     exp_err;
   int     obs_err;
   int     prog_len;
   int     halt_limit;
   int     errors;
   int     tests;
   int     test_start;
   int     cycles;
   logic   logging;
   integer seed = 32'h84c2;

   tb_clk_gen u_clk (
      .rst_req_i (rst_req),
      .clk_o     (clk),
      .rst_n_o   (rst_n)
   );

   cpu_top uut (
      .clk     (clk),
      .rst_n   (rst_n),
      .inst_i  (inst),
      .rdata_i (rdata),
      .iaddr_o (iaddr),
      .daddr_o (daddr),
      .wdata_o (wdata),
      .gran_o  (gran),
      .we_o    (we),
      .re_o    (re),
      .halt_o  (halt),
      .err_o   (err)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Memory models and monitor
   ////////////////////////////////////////////////////////////////////////////

   // Both memories answer in the same cycle
   always @(posedge clk) begin
      #2;
      inst  = imem[iaddr[7:2]];
      rdata = dmem[daddr[9:2]];
   end

   // Sample mid-cycle where outputs have settled
   always @(negedge clk) begin
      if (rst_n && logging) begin
         iaddr_log.push_back(iaddr);
         if (|we) begin
            obs_st.push_back({gran, we, daddr, wdata});
         end
         if (|re) begin
            obs_ld.push_back({gran, re, daddr, 32'h0});
         end
         if (err) begin
            obs_err++;
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: run went past %0d cycles without finishing", MAX_CYCLES);
         $display("Regression failed");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Program building and reference model
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] enc_r(logic [5:0] op, logic [4:0] rd,
                                         logic [4:0] rs, logic [4:0] rt);
      return {op, rd, rs, rt, 11'b0};
   endfunction

   function automatic logic [31:0] enc_i(logic [5:0] op, logic [4:0] rd,
                                         logic [4:0] rs, logic [15:0] imm);
      return {op, rd, rs, imm};
   endfunction

   // Big-endian lanes put byte 0 of the word on lane 3
   function automatic logic [3:0] lane_mask(logic [1:0] g, logic [1:0] ofs);
      case (g)
         2'b01:   return 4'b1000 >> ofs;
         2'b10:   return 4'b1100 >> ofs;
         default: return 4'b1111;
      endcase
   endfunction

   task automatic fill_dmem();
      int         i;
      logic [7:0] idx;
      for (i = 0; i < DMEM_WORDS; i++) begin
         idx     = i[7:0];
         dmem[i] = {idx, ~idx, 8'h5a, idx ^ 8'hc3};
      end
   endtask

   task automatic clear_program();
      int i;
      for (i = 0; i < IMEM_WORDS; i++) begin
         imem[i] = '0;
      end
      prog_len   = 0;
      halt_limit = 0;
   endtask

   task automatic emit(input logic [31:0] ins);
      // PC freezes one word past the first HALT
      if ((ins[31:26] == OP_HALT) && (halt_limit == 0)) begin
         halt_limit = 4 * prog_len + 4;
      end
      imem[prog_len] = ins;
      prog_len++;
   endtask

   task automatic run_model();
      int          pc;
      logic        done;
      logic        wr;
      logic [31:0] ins;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm;
      logic [31:0] ea;
      logic [31:0] res;
      logic [1:0]  g;
      for (pc = 0; pc < 32; pc++) begin
         mregs[pc] = '0;
      end
      exp_st.delete();
      exp_ld.delete();
      exp_err = 0;
      pc      = 0;
      done    = 1'b0;
      while (!done && (pc < IMEM_WORDS)) begin
         ins = imem[pc];
         a   = mregs[ins[20:16]];
         b   = mregs[ins[15:11]];
         imm = {{16{ins[15]}}, ins[15:0]};
         ea  = a + imm;
         wr  = 1'b1;
         res = '0;
         case (ins[31:26])
            OP_LH, OP_SH: g = 2'b10;
            OP_LB, OP_SB: g = 2'b01;
            default:      g = 2'b00;
         endcase
         case (ins[31:26])
            OP_NOP: wr = 1'b0;
            OP_HALT: begin
               wr   = 1'b0;
               done = 1'b1;
            end
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_ADDI: res = ea;
            OP_LW, OP_LH, OP_LB: begin
               res = dmem[ea[9:2]];
               exp_ld.push_back({g, lane_mask(g, ea[1:0]), ea, 32'h0});
            end
            // Store data is the register named in rd
            OP_SW, OP_SH, OP_SB: begin
               wr = 1'b0;
               exp_st.push_back({g, lane_mask(g, ea[1:0]), ea, mregs[ins[25:21]]});
            end
            default: begin
               wr = 1'b0;
               exp_err++;
            end
         endcase
         if (wr && (ins[25:21] != 5'd0)) begin
            mregs[ins[25:21]] = res;
         end
         pc++;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Run control and checking
   ////////////////////////////////////////////////////////////////////////////

   task automatic start_program();
      logging = 1'b0;
      run_model();
      obs_st.delete();
      obs_ld.delete();
      iaddr_log.delete();
      obs_err = 0;
      @(posedge clk);
      #2 rst_req = 1'b1;
      wait (rst_n === 1'b0);
      rst_req = 1'b0;
      wait (rst_n === 1'b1);
      logging = 1'b1;
   endtask

   task automatic check_access(input string kind, input logic [69:0] want,
                               input logic [69:0] got);
      if (got !== want) begin
         errors++;
         $display("Mismatch at %0t: %s gran %b lanes %b addr %h data %h, expected %b %b %h %h",
                  $time, kind, got[69:68], got[67:64], got[63:32], got[31:0],
                  want[69:68], want[67:64], want[63:32], want[31:0]);
      end
   endtask

   task automatic finish_program();
      int i;
      while (halt !== 1'b1) begin
         @(negedge clk);
      end
      // Let anything behind the HALT reach the data port
      repeat (2) @(negedge clk);
      if (obs_st.size() != exp_st.size()) begin
         errors++;
         $display("Mismatch at %0t: %0d stores seen, expected %0d",
                  $time, obs_st.size(), exp_st.size());
      end else begin
         for (i = 0; i < exp_st.size(); i++) begin
            check_access("store", exp_st[i], obs_st[i]);
         end
      end
      if (obs_ld.size() != exp_ld.size()) begin
         errors++;
         $display("Mismatch at %0t: %0d loads seen, expected %0d",
                  $time, obs_ld.size(), exp_ld.size());
      end else begin
         for (i = 0; i < exp_ld.size(); i++) begin
            check_access("load", exp_ld[i], obs_ld[i]);
         end
      end
      if (obs_err != exp_err) begin
         errors++;
         $display("Mismatch at %0t: err_o high for %0d cycles, expected %0d",
                  $time, obs_err, exp_err);
      end
   endtask

   // Repeated fetch addresses below the halt point come from stalls
   function automatic int count_repeats(int limit);
      int i;
      int n;
      n = 0;
      for (i = 1; i < iaddr_log.size(); i++) begin
         if ((iaddr_log[i] == iaddr_log[i-1]) && (iaddr_log[i] < limit)) begin
            n++;
         end
      end
      return n;
   endfunction

   task automatic begin_test();
      test_start = errors;
      tests++;
   endtask

   task automatic end_test(input string name);
      if (errors == test_start) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: %0d errors", name, errors - test_start);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic test_reset();
      int i;
      begin_test();
      clear_program();
      for (i = 0; i < 8; i++) begin
         emit(32'h0);
      end
      emit(enc_i(OP_HALT, 5'd0, 5'd0, 16'h0));
      start_program();
      @(negedge clk);
      if ((we !== 4'b0) || (re !== 4'b0) || (halt !== 1'b0) || (err !== 1'b0)) begin
         errors++;
         $display("Mismatch at %0t: outputs after reset we %b re %b halt %b err %b",
                  $time, we, re, halt, err);
      end
      if (iaddr !== 32'h0) begin
         errors++;
         $display("Mismatch at %0t: iaddr_o %h after reset, expected 0", $time, iaddr);
      end
      finish_program();
      for (i = 0; i < 4; i++) begin
         if (iaddr_log[i] !== 4 * i) begin
            errors++;
            $display("Mismatch at %0t: fetch %0d at %h, expected %h",
                     $time, i, iaddr_log[i], 4 * i);
         end
      end
      end_test("reset");
   endtask

   task automatic test_alu_forward();
      logic [31:0] rnd;
      logic [15:0] v1;
      logic [15:0] v2;
      begin_test();
      rnd = $random(seed);
      v1  = rnd[15:0];
      rnd = $random(seed);
      v2  = rnd[15:0];
      clear_program();
      emit(enc_i(OP_ADDI, 5'd1, 5'd0, v1));
      emit(enc_i(OP_ADDI, 5'd2, 5'd0, v2));
      emit(enc_r(OP_ADD, 5'd3, 5'd1, 5'd2));
      emit(enc_r(OP_SUB, 5'd4, 5'd3, 5'd1));
      emit(enc_r(OP_AND, 5'd5, 5'd4, 5'd3));
      emit(enc_r(OP_OR, 5'd6, 5'd5, 5'd2));
      emit(enc_r(OP_XOR, 5'd7, 5'd6, 5'd4));
      emit(enc_i(OP_SW, 5'd7, 5'd0, 16'h0100));
      emit(enc_i(OP_SW, 5'd3, 5'd0, 16'h0104));
      emit(enc_i(OP_SW, 5'd4, 5'd0, 16'h0108));
      emit(enc_i(OP_SW, 5'd5, 5'd0, 16'h010c));
      emit(enc_i(OP_SW, 5'd6, 5'd0, 16'h0110));
      emit(enc_i(OP_HALT, 5'd0, 5'd0, 16'h0));
      start_program();
      finish_program();
      if (count_repeats(halt_limit) != 0) begin
         errors++;
         $display("Mismatch at %0t: %0d stalls without a load", $time,
                  count_repeats(halt_limit));
      end
      end_test("alu_forward");
   endtask

   task automatic test_load_use();
      logic [31:0] rnd;
      logic [15:0] v1;
      logic [31:0] want;
      begin_test();
      rnd  = $random(seed);
      v1   = rnd[15:0];
      want = dmem[8] + {{16{v1[15]}}, v1};
      clear_program();
      emit(enc_i(OP_ADDI, 5'd1, 5'd0, v1));
      emit(enc_i(OP_LW, 5'd2, 5'd0, 16'h0020));
      emit(enc_r(OP_ADD, 5'd3, 5'd2, 5'd1));
      emit(enc_i(OP_SW, 5'd3, 5'd0, 16'h0060));
      emit(enc_i(OP_HALT, 5'd0, 5'd0, 16'h0));
      start_program();
      finish_program();
      if ((obs_st.size() == 1) && (obs_st[0][31:0] !== want)) begin
         errors++;
         $display("Mismatch at %0t: stored %h, expected loaded word plus addend %h",
                  $time, obs_st[0][31:0], want);
      end
      if (count_repeats(halt_limit) != 1) begin
         errors++;
         $display("Mismatch at %0t: fetch address repeated %0d times, expected 1",
                  $time, count_repeats(halt_limit));
      end
      end_test("load_use");
   endtask

   task automatic test_granularity();
      int          i;
      logic [31:0] rnd;
      begin_test();
      rnd = $random(seed);
      clear_program();
      emit(enc_i(OP_ADDI, 5'd1, 5'd0, rnd[15:0]));
      for (i = 0; i < 4; i++) begin
         emit(enc_i(OP_SB, 5'd1, 5'd0, 16'h0200 + i[15:0]));
      end
      emit(enc_i(OP_SH, 5'd1, 5'd0, 16'h0200));
      emit(enc_i(OP_SH, 5'd1, 5'd0, 16'h0202));
      for (i = 0; i < 4; i++) begin
         emit(enc_i(OP_LB, 5'd2 + i[4:0], 5'd0, 16'h0200 + i[15:0]));
      end
      emit(enc_i(OP_LH, 5'd6, 5'd0, 16'h0200));
      emit(enc_i(OP_LH, 5'd7, 5'd0, 16'h0202));
      emit(enc_i(OP_HALT, 5'd0, 5'd0, 16'h0));
      start_program();
      finish_program();
      end_test("granularity");
   endtask

   task automatic test_halt_illegal();
      int          i;
      logic [31:0] rnd;
      logic [31:0] held;
      begin_test();
      rnd = $random(seed);
      clear_program();
      emit(enc_i(OP_ADDI, 5'd1, 5'd0, rnd[15:0]));
      // Unused opcode with store-like fields
      emit({6'h3f, 5'd1, 5'd0, 16'h0300});
      emit(enc_i(OP_HALT, 5'd0, 5'd0, 16'h0));
      emit(enc_i(OP_SW, 5'd1, 5'd0, 16'h0304));
      emit(enc_i(OP_ADDI, 5'd2, 5'd0, 16'h0001));
      start_program();
      finish_program();
      held = iaddr;
      for (i = 0; i < 6; i++) begin
         @(negedge clk);
         if (halt !== 1'b1) begin
            errors++;
            $display("Mismatch at %0t: halt_o dropped to %b", $time, halt);
         end
         if (iaddr !== held) begin
            errors++;
            $display("Mismatch at %0t: iaddr_o %h moved after halt, held %h",
                     $time, iaddr, held);
         end
      end
      if (obs_st.size() != 0) begin
         errors++;
         $display("Mismatch at %0t: %0d stores after illegal and HALT, expected 0",
                  $time, obs_st.size());
      end
      end_test("halt_illegal");
   endtask

   initial begin
      rst_req = 1'b0;
      inst    = '0;
      rdata   = '0;
      errors  = 0;
      tests   = 0;
      cycles  = 0;
      obs_err = 0;
      logging = 1'b0;
      fill_dmem();
      clear_program();
      wait (rst_n === 1'b1);
      test_reset();
      test_alu_forward();
      test_load_use();
      test_granularity();
      test_halt_illegal();
      $display("Tests run: %0d, errors: %0d", tests, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
   input  logic rst_req_i,
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #20 clk_o = ~clk_o;
   end

   // Three cycles of reset at start and again on every request
   initial begin
      rst_n_o = 1'b0;
      forever begin
         repeat (3) @(posedge clk_o);
         #2 rst_n_o = 1'b1;
         @(posedge rst_req_i);
         rst_n_o = 1'b0;
      end
   end

endmodule

//--- flist.f
+incdir+src
src/cpu_pkg.sv
src/stage_reg.sv
src/decode_stage.sv
src/hazard_forward.sv
src/execute_stage.sv
src/mem_access.sv
src/cpu_top.sv
dv/tb_clk_gen.sv
dv/cpu_tb.sv

//--- src/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath widths
`define CPU_XLEN        32
`define CPU_REG_ADDR_W  5
`define CPU_OPC_W       6
`define CPU_IMM_W       16
`define CPU_LANES       4
`define CPU_PC_STEP     4

// Instruction fields
`define CPU_OPC_HI      31
`define CPU_OPC_LO      26
`define CPU_RD_HI       25
`define CPU_RD_LO       21
`define CPU_RS_HI       20
`define CPU_RS_LO       16
`define CPU_RT_HI       15
`define CPU_RT_LO       11
`define CPU_IMM_HI      15
`define CPU_IMM_LO      0

`endif

//--- src/cpu_pkg.sv
`include "cpu_defs.svh"

package cpu_pkg;

   typedef enum logic [`CPU_OPC_W-1:0] {
      OP_NOP  = 6'h00,
      OP_HALT = 6'h01,
      OP_ADD  = 6'h10,
      OP_SUB  = 6'h11,
      OP_AND  = 6'h12,
      OP_OR   = 6'h13,
      OP_XOR  = 6'h14,
      OP_ADDI = 6'h20,
      OP_LW   = 6'h28,
      OP_LH   = 6'h29,
      OP_LB   = 6'h2a,
      OP_SW   = 6'h30,
      OP_SH   = 6'h31,
      OP_SB   = 6'h32
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_XOR = 3'd4
   } alu_op_e;

   // Encoding matches the data port gran_o
   typedef enum logic [1:0] {
      GRAN_WORD = 2'b00,
      GRAN_BYTE = 2'b01,
      GRAN_HALF = 2'b10
   } mem_gran_e;

   typedef enum logic [1:0] {
      FWD_RF    = 2'd0,
      FWD_EXMEM = 2'd1,
      FWD_MEMWB = 2'd2
   } fwd_sel_e;

   typedef struct packed {
      logic [`CPU_XLEN-1:0] inst;
      logic [`CPU_XLEN-1:0] pc;
   } if_id_t;

   typedef struct packed {
      logic [`CPU_XLEN-1:0]       op_a;
      logic [`CPU_XLEN-1:0]       op_b;
      logic [`CPU_XLEN-1:0]       imm;
      logic [`CPU_REG_ADDR_W-1:0] src_a;
      logic [`CPU_REG_ADDR_W-1:0] src_b;
      logic [`CPU_REG_ADDR_W-1:0] rd;
      alu_op_e                    alu_op;
      logic                       use_imm;
      logic                       reg_write;
      logic                       mem_read;
      logic                       mem_write;
      mem_gran_e                  gran;
      logic                       halt;
      logic                       illegal;
   } id_ex_t;

   typedef struct packed {
      logic [`CPU_XLEN-1:0]       result;
      logic [`CPU_XLEN-1:0]       store_data;
      logic [`CPU_REG_ADDR_W-1:0] rd;
      logic                       reg_write;
      logic                       mem_read;
      logic                       mem_write;
      mem_gran_e                  gran;
      logic                       halt;
      logic                       illegal;
   } ex_mem_t;

endpackage

//--- src/cpu_top.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_top
   import cpu_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic [`CPU_XLEN-1:0]  inst_i,
   input  logic [`CPU_XLEN-1:0]  rdata_i,
   output logic [`CPU_XLEN-1:0]  iaddr_o,
   output logic [`CPU_XLEN-1:0]  daddr_o,
   output logic [`CPU_XLEN-1:0]  wdata_o,
   output logic [1:0]            gran_o,
   output logic [`CPU_LANES-1:0] we_o,
   output logic [`CPU_LANES-1:0] re_o,
   output logic                  halt_o,
   output logic                  err_o
);

   logic [`CPU_XLEN-1:0]       pc_q;
   logic                       halted_q;
   logic                       halting;
   logic                       stall;
   if_id_t                     if_id_d;
   if_id_t                     if_id_q;
   id_ex_t                     id_ex_d;
   id_ex_t                     id_ex_q;
   ex_mem_t                    ex_mem_q;
   fwd_sel_e                   fwd_a;
   fwd_sel_e                   fwd_b;
   logic [`CPU_REG_ADDR_W-1:0] src_a;
   logic [`CPU_REG_ADDR_W-1:0] src_b;
   logic                       uses_b;
   logic                       is_halt;
   logic                       wb_we;
   logic [`CPU_REG_ADDR_W-1:0] wb_rd;
   logic [`CPU_XLEN-1:0]       wb_data;

   /////////////////////////////////////////////////////////////////////////////
   // Fetch
   /////////////////////////////////////////////////////////////////////////////

   // HALT in ID already blocks the next fetch
   assign halting = halted_q | is_halt;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc_q     <= '0;
         halted_q <= 1'b0;
      end else begin
         if (is_halt) begin
            halted_q <= 1'b1;
         end
         if (!stall && !halting) begin
            pc_q <= pc_q + `CPU_PC_STEP;
         end
      end
   end

   assign iaddr_o      = pc_q;
   assign if_id_d.inst = halting ? '0 : inst_i;
   assign if_id_d.pc   = pc_q;

   stage_reg #(.T(if_id_t), .BUBBLE(1'b0)) u_if_id (
      .clk     (clk),
      .rst_n   (rst_n),
      .stall_i (stall),
      .d_i     (if_id_d),
      .q_o     (if_id_q)
   );

   /////////////////////////////////////////////////////////////////////////////
   // Decode and hazards
   /////////////////////////////////////////////////////////////////////////////

   decode_stage u_decode (
      .clk       (clk),
      .rst_n     (rst_n),
      .if_id_i   (if_id_q),
      .wb_we_i   (wb_we),
      .wb_rd_i   (wb_rd),
      .wb_data_i (wb_data),
      .id_ex_o   (id_ex_d),
      .src_a_o   (src_a),
      .src_b_o   (src_b),
      .uses_b_o  (uses_b),
      .is_halt_o (is_halt)
   );

   hazard_forward u_hazard (
      .src_a_i    (src_a),
      .src_b_i    (src_b),
      .uses_b_i   (uses_b),
      .ex_src_a_i (id_ex_q.src_a),
      .ex_src_b_i (id_ex_q.src_b),
      .ex_rd_i    (id_ex_q.rd),
      .ex_load_i  (id_ex_q.mem_read),
      .ex_regw_i  (id_ex_q.reg_write),
      .mem_rd_i   (ex_mem_q.rd),
      .mem_regw_i (ex_mem_q.reg_write),
      .wb_rd_i    (wb_rd),
      .wb_we_i    (wb_we),
      .fwd_a_o    (fwd_a),
      .fwd_b_o    (fwd_b),
      .stall_o    (stall)
   );

   stage_reg #(.T(id_ex_t), .BUBBLE(1'b1)) u_id_ex (
      .clk     (clk),
      .rst_n   (rst_n),
      .stall_i (stall),
      .d_i     (id_ex_d),
      .q_o     (id_ex_q)
   );

   /////////////////////////////////////////////////////////////////////////////
   // Execute, memory and writeback
   /////////////////////////////////////////////////////////////////////////////

   execute_stage u_execute (
      .clk       (clk),
      .rst_n     (rst_n),
      .id_ex_i   (id_ex_q),
      .fwd_a_i   (fwd_a),
      .fwd_b_i   (fwd_b),
      .wb_data_i (wb_data),
      .ex_mem_o  (ex_mem_q)
   );

   mem_access u_mem (
      .clk       (clk),
      .rst_n     (rst_n),
      .ex_mem_i  (ex_mem_q),
      .rdata_i   (rdata_i),
      .daddr_o   (daddr_o),
      .wdata_o   (wdata_o),
      .gran_o    (gran_o),
      .we_o      (we_o),
      .re_o      (re_o),
      .wb_we_o   (wb_we),
      .wb_rd_o   (wb_rd),
      .wb_data_o (wb_data),
      .halt_o    (halt_o),
      .err_o     (err_o)
   );

endmodule

//--- src/decode_stage.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module decode_stage
   import cpu_pkg::*;
(
   input  logic                       clk,
   input  logic                       rst_n,
   input  if_id_t                     if_id_i,
   input  logic                       wb_we_i,
   input  logic [`CPU_REG_ADDR_W-1:0] wb_rd_i,
   input  logic [`CPU_XLEN-1:0]       wb_data_i,
   output id_ex_t                     id_ex_o,
   output logic [`CPU_REG_ADDR_W-1:0] src_a_o,
   output logic [`CPU_REG_ADDR_W-1:0] src_b_o,
   output logic                       uses_b_o,
   output logic                       is_halt_o
);

   logic [`CPU_XLEN-1:0]       regs [0:(1 << `CPU_REG_ADDR_W) - 1];
   logic [`CPU_OPC_W-1:0]      opc;
   logic [`CPU_REG_ADDR_W-1:0] rd_f;
   logic [`CPU_REG_ADDR_W-1:0] rs_f;
   logic [`CPU_REG_ADDR_W-1:0] rt_f;
   logic [`CPU_XLEN-1:0]       imm_ext;
   logic                       writes_rd;

   function automatic mem_gran_e gran_of(input logic [`CPU_OPC_W-1:0] op);
      case (op)
         OP_LH, OP_SH: return GRAN_HALF;
         OP_LB, OP_SB: return GRAN_BYTE;
         default:      return GRAN_WORD;
      endcase
   endfunction

   // Write-before-read so WB and ID can share a cycle
   function automatic logic [`CPU_XLEN-1:0] rf_read(input logic [`CPU_REG_ADDR_W-1:0] idx);
      if (idx == '0) begin
         return '0;
      end
      if (wb_we_i && (wb_rd_i == idx)) begin
         return wb_data_i;
      end
      return regs[idx];
   endfunction

   assign opc     = if_id_i.inst[`CPU_OPC_HI:`CPU_OPC_LO];
   assign rd_f    = if_id_i.inst[`CPU_RD_HI:`CPU_RD_LO];
   assign rs_f    = if_id_i.inst[`CPU_RS_HI:`CPU_RS_LO];
   assign rt_f    = if_id_i.inst[`CPU_RT_HI:`CPU_RT_LO];
   assign imm_ext = {{(`CPU_XLEN - `CPU_IMM_W){if_id_i.inst[`CPU_IMM_HI]}},
                     if_id_i.inst[`CPU_IMM_HI:`CPU_IMM_LO]};

   always_comb begin
      id_ex_o       = '0;
      writes_rd     = 1'b0;
      uses_b_o      = 1'b0;
      id_ex_o.imm   = imm_ext;
      id_ex_o.src_a = rs_f;
      id_ex_o.rd    = rd_f;
      case (opc)
         OP_NOP: begin
         end
         OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
            writes_rd     = 1'b1;
            uses_b_o      = 1'b1;
            id_ex_o.src_b = rt_f;
            case (opc)
               OP_SUB:  id_ex_o.alu_op = ALU_SUB;
               OP_AND:  id_ex_o.alu_op = ALU_AND;
               OP_OR:   id_ex_o.alu_op = ALU_OR;
               OP_XOR:  id_ex_o.alu_op = ALU_XOR;
               default: id_ex_o.alu_op = ALU_ADD;
            endcase
         end
         OP_ADDI: begin
            writes_rd       = 1'b1;
            id_ex_o.use_imm = 1'b1;
         end
         OP_LW, OP_LH, OP_LB: begin
            writes_rd        = 1'b1;
            id_ex_o.use_imm  = 1'b1;
            id_ex_o.mem_read = 1'b1;
            id_ex_o.gran     = gran_of(opc);
         end
         // Store data comes from the rd field
         OP_SW, OP_SH, OP_SB: begin
            uses_b_o          = 1'b1;
            id_ex_o.src_b     = rd_f;
            id_ex_o.use_imm   = 1'b1;
            id_ex_o.mem_write = 1'b1;
            id_ex_o.gran      = gran_of(opc);
         end
         OP_HALT: begin
            id_ex_o.halt = 1'b1;
         end
         default: begin
            id_ex_o.illegal = 1'b1;
         end
      endcase
      // r0 targets are dropped here so later stages never see them
      id_ex_o.reg_write = writes_rd && (rd_f != '0);
      id_ex_o.op_a      = rf_read(id_ex_o.src_a);
      id_ex_o.op_b      = rf_read(id_ex_o.src_b);
   end

   assign src_a_o   = id_ex_o.src_a;
   assign src_b_o   = id_ex_o.src_b;
   assign is_halt_o = id_ex_o.halt;

   always_ff @(posedge clk) begin
      if (wb_we_i) begin
         regs[wb_rd_i] <= wb_data_i;
      end
   end

   a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
      wb_we_i |-> (wb_rd_i != '0));

endmodule

//--- src/execute_stage.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module execute_stage
   import cpu_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  id_ex_t               id_ex_i,
   input  fwd_sel_e             fwd_a_i,
   input  fwd_sel_e             fwd_b_i,
   input  logic [`CPU_XLEN-1:0] wb_data_i,
   output ex_mem_t              ex_mem_o
);

   logic [`CPU_XLEN-1:0] opnd_a;
   logic [`CPU_XLEN-1:0] opnd_b;
   logic [`CPU_XLEN-1:0] alu_b;
   logic [`CPU_XLEN-1:0] alu_res;

   function automatic logic [`CPU_XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                                     input logic [`CPU_XLEN-1:0] rf_val);
      case (sel)
         FWD_EXMEM: return ex_mem_o.result;
         FWD_MEMWB: return wb_data_i;
         default:   return rf_val;
      endcase
   endfunction

   assign opnd_a = fwd_mux(fwd_a_i, id_ex_i.op_a);
   assign opnd_b = fwd_mux(fwd_b_i, id_ex_i.op_b);

   // Base plus offset for ADDI and memory ops
   assign alu_b = id_ex_i.use_imm ? id_ex_i.imm : opnd_b;

   always_comb begin
      case (id_ex_i.alu_op)
         ALU_SUB: alu_res = opnd_a - alu_b;
         ALU_AND: alu_res = opnd_a & alu_b;
         ALU_OR:  alu_res = opnd_a | alu_b;
         ALU_XOR: alu_res = opnd_a ^ alu_b;
         default: alu_res = opnd_a + alu_b;
      endcase
   end

   /////////////////////////////////////////////////////////////////////////////
   // EX/MEM register
   /////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ex_mem_o <= '0;
      end else begin
         ex_mem_o.result     <= alu_res;
         ex_mem_o.store_data <= opnd_b;
         ex_mem_o.rd         <= id_ex_i.rd;
         ex_mem_o.reg_write  <= id_ex_i.reg_write;
         ex_mem_o.mem_read   <= id_ex_i.mem_read;
         ex_mem_o.mem_write  <= id_ex_i.mem_write;
         ex_mem_o.gran       <= id_ex_i.gran;
         ex_mem_o.halt       <= id_ex_i.halt;
         ex_mem_o.illegal    <= id_ex_i.illegal;
      end
   end

endmodule

//--- src/hazard_forward.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module hazard_forward
   import cpu_pkg::*;
(
   input  logic [`CPU_REG_ADDR_W-1:0] src_a_i,
   input  logic [`CPU_REG_ADDR_W-1:0] src_b_i,
   input  logic                       uses_b_i,
   input  logic [`CPU_REG_ADDR_W-1:0] ex_src_a_i,
   input  logic [`CPU_REG_ADDR_W-1:0] ex_src_b_i,
   input  logic [`CPU_REG_ADDR_W-1:0] ex_rd_i,
   input  logic                       ex_load_i,
   input  logic                       ex_regw_i,
   input  logic [`CPU_REG_ADDR_W-1:0] mem_rd_i,
   input  logic                       mem_regw_i,
   input  logic [`CPU_REG_ADDR_W-1:0] wb_rd_i,
   input  logic                       wb_we_i,
   output fwd_sel_e                   fwd_a_o,
   output fwd_sel_e                   fwd_b_o,
   output logic                       stall_o
);

   // Youngest producer wins
   function automatic fwd_sel_e pick(input logic [`CPU_REG_ADDR_W-1:0] src);
      if (mem_regw_i && (mem_rd_i != '0) && (mem_rd_i == src)) begin
         return FWD_EXMEM;
      end
      if (wb_we_i && (wb_rd_i != '0) && (wb_rd_i == src)) begin
         return FWD_MEMWB;
      end
      return FWD_RF;
   endfunction

   assign fwd_a_o = pick(ex_src_a_i);
   assign fwd_b_o = pick(ex_src_b_i);

   // Load data is not ready until MEM/WB so hold ID one cycle
   assign stall_o = ex_load_i && ex_regw_i && (ex_rd_i != '0) &&
                    ((ex_rd_i == src_a_i) || (uses_b_i && (ex_rd_i == src_b_i)));

endmodule

//--- src/mem_access.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module mem_access
   import cpu_pkg::*;
(
   input  logic                       clk,
   input  logic                       rst_n,
   input  ex_mem_t                    ex_mem_i,
   input  logic [`CPU_XLEN-1:0]       rdata_i,
   output logic [`CPU_XLEN-1:0]       daddr_o,
   output logic [`CPU_XLEN-1:0]       wdata_o,
   output logic [1:0]                 gran_o,
   output logic [`CPU_LANES-1:0]      we_o,
   output logic [`CPU_LANES-1:0]      re_o,
   output logic                       wb_we_o,
   output logic [`CPU_REG_ADDR_W-1:0] wb_rd_o,
   output logic [`CPU_XLEN-1:0]       wb_data_o,
   output logic                       halt_o,
   output logic                       err_o
);

   logic [`CPU_LANES-1:0] lanes;

   assign daddr_o = ex_mem_i.result;
   assign wdata_o = ex_mem_i.store_data;
   assign gran_o  = ex_mem_i.gran;

   // Big-endian lanes so byte 0 of the word sits on lane 3
   always_comb begin
      case (ex_mem_i.gran)
         GRAN_WORD: lanes = 4'b1111;
         GRAN_HALF: lanes = 4'b1100 >> daddr_o[1:0];
         GRAN_BYTE: lanes = 4'b1000 >> daddr_o[1:0];
         default:   lanes = '0;
      endcase
   end

   assign we_o = {`CPU_LANES{ex_mem_i.mem_write}} & lanes;
   assign re_o = {`CPU_LANES{ex_mem_i.mem_read}} & lanes;

   /////////////////////////////////////////////////////////////////////////////
   // MEM/WB register
   /////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wb_we_o <= 1'b0;
         wb_rd_o <= '0;
         err_o   <= 1'b0;
         halt_o  <= 1'b0;
      end else begin
         wb_we_o <= ex_mem_i.reg_write;
         wb_rd_o <= ex_mem_i.rd;
         err_o   <= ex_mem_i.illegal;
         halt_o  <= halt_o | ex_mem_i.halt;   // sticky until reset
      end
   end

   always_ff @(posedge clk) begin
      wb_data_o <= ex_mem_i.mem_read ? rdata_i : ex_mem_i.result;
   end

   a_rw_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
      !((|we_o) && (|re_o)));

endmodule

//--- src/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
   parameter type T      = logic,
   parameter bit  BUBBLE = 1'b0
) (
   input  logic clk,
   input  logic rst_n,
   input  logic stall_i,
   input  T     d_i,
   output T     q_o
);

   // Zero payload is a NOP
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         q_o <= '0;
      end else if (!stall_i) begin
         q_o <= d_i;
      end else if (BUBBLE) begin
         q_o <= '0;
      end
   end

   // A stalled cycle must hand a bubble to the next stage
   a_bubble_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
      (BUBBLE && stall_i) |=> (q_o == '0));

endmodule
